// File: pcs_pkg.sv
`default_nettype none

package pcs_pkg;

	////////////////////
	// Block widths
	////////////////////
	localparam int LEN_DATA_BLOCK  = 64;	// Decoded data
	localparam int LEN_CTRL_BLOCK  = 8;	// One flag per byte
	localparam int LEN_CODED_BLOCK = 66;	// Sync header plus payload

	localparam int IDLE_PERIOD = 8;	// Every eighth block is idle

	// Self-synchronizing scrambler, x^58 + x^39 + 1
	localparam int SCR_LEN = 58;
	localparam int SCR_TAP = 39;

	// Characters on the decoded side
	localparam logic [7:0] IDLE_CHAR  = 8'h07;
	localparam logic [7:0] ERROR_CHAR = 8'hFE;

	// 7-bit control codes inside a coded control block
	localparam logic [6:0] IDLE_CODE  = 7'h00;
	localparam logic [6:0] ERROR_CODE = 7'h1E;

	typedef enum logic [1:0] {
		SYNC_DATA = 2'b01,
		SYNC_CTRL = 2'b10
	} sync_hdr_e;

	typedef enum logic [7:0] {
		TYPE_IDLE = 8'h1E	// Eight control codes follow
	} block_type_e;

endpackage

`default_nettype wire

// File: regfile_pkg.sv
`default_nettype none

package regfile_pkg;

	localparam int NB_GPIOS  = 32;
	localparam int NB_OPCODE = 9;

	////////////////////
	// Command word
	////////////////////
	localparam int STROBE_BIT = 31;
	localparam int OPCODE_MSB = 30;
	localparam int OPCODE_LSB = 22;
	localparam int NB_ARG     = 22;	// Argument in bits 21..0

	typedef enum logic [NB_OPCODE-1:0] {
		OP_NOP          = 9'd0,
		OP_TX_ENABLE    = 9'd1,	// Arg bit 0
		OP_RX_ENABLE    = 9'd2,	// Arg bit 0
		OP_LOG_RUN      = 9'd3,	// Arg bit 0, run or stop
		OP_SET_ADDR     = 9'd4,
		OP_READ_DATA_LO = 9'd5,
		OP_READ_DATA_HI = 9'd6,
		OP_READ_CTRL    = 9'd7,
		OP_READ_STATUS  = 9'd8
	} opcode_e;

endpackage

`default_nettype wire

// File: log_port_if.sv
`timescale 1ns/100ps
`default_nettype none

interface log_port_if
#(
	parameter int NB_WORD   = 64,
	parameter int RAM_DEPTH = 64
);

	localparam int NB_ADDR = $clog2(RAM_DEPTH);

	logic                 run;
	logic [NB_ADDR-1:0]   read_addr;
	logic [NB_WORD-1:0]   read_data;	// Registered read
	logic                 full;
	logic [NB_ADDR:0]     count;	// Holds RAM_DEPTH itself

	// Register file side
	modport ctrl (
		output run,
		output read_addr,
		input  read_data,
		input  full,
		input  count
	);

	// Memory side
	modport mem (
		input  run,
		input  read_addr,
		output read_data,
		output full,
		output count
	);

endinterface

`default_nettype wire

// File: pcs_tx_path.sv
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_path
	import pcs_pkg::*;
(
	input  wire logic                        i_clock,
	input  wire logic                        i_rst_n,
	input  wire logic                        i_enable,
	output logic      [LEN_CODED_BLOCK-1:0]  o_block,
	output logic                             o_valid
);

	localparam int NB_COUNT = 32;
	localparam int NB_PHASE = $clog2(IDLE_PERIOD);
	localparam int N_LANES  = LEN_DATA_BLOCK / 8;

	logic [NB_COUNT-1:0]        block_cnt;	// Block index k
	logic [LEN_DATA_BLOCK-1:0]  tx_data;
	logic [LEN_CTRL_BLOCK-1:0]  tx_ctrl;
	logic [LEN_CODED_BLOCK-1:0] coded;
	logic [LEN_CODED_BLOCK-1:0] enc_block;
	logic                       enc_valid;
	logic [SCR_LEN-1:0]         scr_state;
	logic [SCR_LEN-1:0]         scr_next;
	logic [LEN_DATA_BLOCK-1:0]  scr_payload;

	////////////////////
	// Block generator
	////////////////////
	always_comb begin
		if (block_cnt[NB_PHASE-1:0] == NB_PHASE'(IDLE_PERIOD - 1)) begin
			tx_ctrl = '1;
			tx_data = {N_LANES{IDLE_CHAR}};
		end else begin
			tx_ctrl = '0;
			tx_data = {block_cnt, ~block_cnt};	// k high, inverse low
		end
	end

	////////////////////
	// 64b/66b encoder
	////////////////////
	always_comb begin
		if (tx_ctrl == '0) begin
			coded = {SYNC_DATA, tx_data};
		end else if (tx_data == {N_LANES{IDLE_CHAR}}) begin
			coded = {SYNC_CTRL, {N_LANES{IDLE_CODE}}, TYPE_IDLE};
		end else begin
			// Anything else goes out as an error block
			coded = {SYNC_CTRL, {N_LANES{ERROR_CODE}}, TYPE_IDLE};
		end
	end

	////////////////////
	// Scrambler
	////////////////////
	// Bit 0 goes first, header is sent in the clear
	always_comb begin
		scr_next = scr_state;
		for (int i = 0; i < LEN_DATA_BLOCK; i++) begin
			scr_payload[i] = enc_block[i] ^ scr_next[SCR_TAP-1] ^ scr_next[SCR_LEN-1];
			scr_next       = {scr_next[SCR_LEN-2:0], scr_payload[i]};
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			block_cnt <= '0;
			enc_valid <= 1'b0;
			o_valid   <= 1'b0;
			scr_state <= '0;
		end else begin
			enc_valid <= i_enable;
			o_valid   <= enc_valid;
			block_cnt <= i_enable ? block_cnt + 1'b1 : '0;	// Restart at k = 0
			if (enc_valid) begin
				scr_state <= scr_next;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_enable) begin
			enc_block <= coded;	// Stage 1
		end
		if (enc_valid) begin
			o_block <= {enc_block[LEN_CODED_BLOCK-1 -: 2], scr_payload};	// Stage 2
		end
	end

endmodule

`default_nettype wire

// File: pcs_rx_path.sv
`timescale 1ns/100ps
`default_nettype none

module pcs_rx_path
	import pcs_pkg::*;
(
	input  wire logic                        i_clock,
	input  wire logic                        i_rst_n,
	input  wire logic                        i_enable,
	input  wire logic [LEN_CODED_BLOCK-1:0]  i_block,
	input  wire logic                        i_valid,
	output logic      [LEN_DATA_BLOCK-1:0]   o_rx_raw_data,
	output logic      [LEN_CTRL_BLOCK-1:0]   o_rx_raw_ctrl,
	output logic                             o_valid
);

	localparam int N_LANES = LEN_DATA_BLOCK / 8;

	logic [SCR_LEN-1:0]         dsc_state;
	logic [SCR_LEN-1:0]         dsc_next;
	logic [LEN_DATA_BLOCK-1:0]  dsc_payload;
	logic [LEN_CODED_BLOCK-1:0] dsc_block;
	logic                       dsc_valid;
	sync_hdr_e                  rx_hdr;
	block_type_e                rx_type;
	logic [LEN_DATA_BLOCK-1:0]  dec_data;
	logic [LEN_CTRL_BLOCK-1:0]  dec_ctrl;

	////////////////////
	// Descrambler
	////////////////////
	// State is fed from the line bits, so it tracks the transmitter on its own
	always_comb begin
		dsc_next = dsc_state;
		for (int i = 0; i < LEN_DATA_BLOCK; i++) begin
			dsc_payload[i] = i_block[i] ^ dsc_next[SCR_TAP-1] ^ dsc_next[SCR_LEN-1];
			dsc_next       = {dsc_next[SCR_LEN-2:0], i_block[i]};
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			dsc_state <= '0;
			dsc_valid <= 1'b0;
			o_valid   <= 1'b0;
		end else begin
			if (i_valid) begin
				dsc_state <= dsc_next;	// Keeps following even while disabled
			end
			dsc_valid <= i_valid & i_enable;
			o_valid   <= dsc_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			dsc_block <= {i_block[LEN_CODED_BLOCK-1 -: 2], dsc_payload};
		end
	end

	////////////////////
	// 64b/66b decoder
	////////////////////
	assign rx_hdr  = sync_hdr_e'(dsc_block[LEN_CODED_BLOCK-1 -: 2]);
	assign rx_type = block_type_e'(dsc_block[7:0]);

	always_comb begin
		dec_data = {N_LANES{ERROR_CHAR}};	// Error unless recognized
		dec_ctrl = '1;
		case (rx_hdr)
			SYNC_DATA: begin
				dec_data = dsc_block[LEN_DATA_BLOCK-1:0];
				dec_ctrl = '0;
			end
			SYNC_CTRL: begin
				if (rx_type == TYPE_IDLE && dsc_block[LEN_DATA_BLOCK-1:8] == '0) begin
					dec_data = {N_LANES{IDLE_CHAR}};
				end
			end
			default: ;	// Invalid sync header
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (dsc_valid) begin
			o_rx_raw_data <= dec_data;
			o_rx_raw_ctrl <= dec_ctrl;
		end
	end

endmodule

`default_nettype wire

// File: log_memory.sv
`timescale 1ns/100ps
`default_nettype none

module log_memory
#(
	parameter int NB_WORD   = 64,
	parameter int RAM_DEPTH = 64
)
(
	input  wire logic                i_clock,
	input  wire logic                i_rst_n,
	input  wire logic [NB_WORD-1:0]  i_data,
	input  wire logic                i_valid,
	log_port_if.mem                  port
);

	localparam int               NB_ADDR    = $clog2(RAM_DEPTH);
	localparam logic [NB_ADDR:0] FULL_COUNT = (NB_ADDR + 1)'(RAM_DEPTH);

	logic [NB_WORD-1:0] mem [RAM_DEPTH];
	logic [NB_ADDR-1:0] wr_ptr;
	logic [NB_ADDR:0]   count;
	logic               full;
	logic               run_d;
	logic               run_rise;
	logic [NB_ADDR-1:0] wr_addr;
	logic [NB_ADDR:0]   base_count;
	logic               wr_en;

	// A rising run restarts the log from address 0
	assign run_rise   = port.run & ~run_d;
	assign wr_addr    = run_rise ? '0 : wr_ptr;
	assign base_count = run_rise ? '0 : count;
	assign wr_en      = port.run & i_valid & (run_rise | ~full);	// Full drops

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			run_d  <= 1'b0;
			wr_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
		end else begin
			run_d <= port.run;
			if (wr_en) begin
				wr_ptr <= wr_addr + 1'b1;
				count  <= base_count + 1'b1;
				full   <= (base_count + 1'b1) == FULL_COUNT;
			end else if (run_rise) begin
				wr_ptr <= '0;
				count  <= '0;
				full   <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (wr_en) begin
			mem[wr_addr] <= i_data;
		end
		port.read_data <= mem[port.read_addr];	// Random read, one cycle
	end

	assign port.full  = full;
	assign port.count = count;

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file
	import regfile_pkg::*;
#(
	parameter int RAM_DEPTH = 64
)
(
	input  wire logic                  i_clock,
	input  wire logic                  i_rst_n,
	input  wire logic [NB_GPIOS-1:0]   i_gpio_in,
	output logic      [NB_GPIOS-1:0]   o_gpio_out,
	log_port_if.ctrl                   data_port,
	log_port_if.ctrl                   ctrl_port,
	output logic                       o_enable_tx,
	output logic                       o_enable_rx,
	output logic                       o_invalid_opcode,
	output logic      [NB_OPCODE-1:0]  o_opcode
);

	localparam int NB_ADDR = $clog2(RAM_DEPTH);

	logic                 strobe_q;
	logic                 cmd_start;
	logic [NB_OPCODE-1:0] cmd_field;
	logic [NB_ARG-1:0]    cmd_arg;
	logic                 cmd_known;
	logic                 log_run;
	logic [NB_ADDR-1:0]   read_addr;
	logic                 cmd_pend;
	logic [NB_OPCODE-1:0] cmd_op;
	logic                 cmd_bad;
	logic                 rd_pend;
	logic [NB_OPCODE-1:0] rd_op;
	logic                 rd_bad;
	logic [NB_GPIOS-1:0]  readback;

	////////////////////
	// Command decode
	////////////////////
	assign cmd_start = i_gpio_in[STROBE_BIT] & ~strobe_q;	// Strobe 0 to 1
	assign cmd_field = i_gpio_in[OPCODE_MSB:OPCODE_LSB];
	assign cmd_arg   = i_gpio_in[NB_ARG-1:0];

	always_comb begin
		case (opcode_e'(cmd_field))
			OP_NOP, OP_TX_ENABLE, OP_RX_ENABLE, OP_LOG_RUN, OP_SET_ADDR,
			OP_READ_DATA_LO, OP_READ_DATA_HI, OP_READ_CTRL, OP_READ_STATUS:
				cmd_known = 1'b1;
			default:
				cmd_known = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			strobe_q    <= 1'b0;
			o_enable_tx <= 1'b0;
			o_enable_rx <= 1'b0;
			log_run     <= 1'b0;
			read_addr   <= '0;
			cmd_pend    <= 1'b0;
			cmd_op      <= '0;
			cmd_bad     <= 1'b0;
		end else begin
			strobe_q <= i_gpio_in[STROBE_BIT];
			cmd_pend <= cmd_start;
			if (cmd_start) begin
				cmd_op  <= cmd_field;
				cmd_bad <= ~cmd_known;
				case (opcode_e'(cmd_field))
					OP_TX_ENABLE: o_enable_tx <= cmd_arg[0];
					OP_RX_ENABLE: o_enable_rx <= cmd_arg[0];
					OP_LOG_RUN:   log_run     <= cmd_arg[0];
					OP_SET_ADDR:  read_addr   <= cmd_arg[NB_ADDR-1:0];
					default: ;	// Reads act in the later stages
				endcase
			end
		end
	end

	assign data_port.run       = log_run;	// Both logs run together
	assign ctrl_port.run       = log_run;
	assign data_port.read_addr = read_addr;
	assign ctrl_port.read_addr = read_addr;

	////////////////////
	// Read-back
	////////////////////
	// Memory read data is valid one cycle after the command edge
	always_comb begin
		readback = '0;
		case (opcode_e'(rd_op))
			OP_READ_DATA_LO: readback = data_port.read_data[NB_GPIOS-1:0];
			OP_READ_DATA_HI: readback = data_port.read_data[2*NB_GPIOS-1:NB_GPIOS];
			OP_READ_CTRL:    readback = NB_GPIOS'(ctrl_port.read_data);
			OP_READ_STATUS: begin
				readback[NB_GPIOS-1] = data_port.full;
				readback[NB_GPIOS-2] = ctrl_port.full;
				readback[NB_ADDR:0]  = data_port.count;
			end
			default: readback = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			rd_pend          <= 1'b0;
			rd_op            <= '0;
			rd_bad           <= 1'b0;
			o_gpio_out       <= '0;
			o_opcode         <= '0;
			o_invalid_opcode <= 1'b0;
		end else begin
			rd_pend <= cmd_pend;
			rd_op   <= cmd_op;
			rd_bad  <= cmd_bad;
			if (rd_pend) begin
				o_gpio_out       <= readback;	// Second edge after the command
				o_opcode         <= rd_op;
				o_invalid_opcode <= rd_bad;	// Held until the next command
			end
		end
	end

endmodule

`default_nettype wire

// File: verification_top_level.sv
`timescale 1ns/100ps
`default_nettype none

module verification_top_level
	import pcs_pkg::*;
	import regfile_pkg::*;
#(
	parameter int RAM_DEPTH = 64
)
(
	input  wire logic                  i_clock,
	input  wire logic                  i_rst_n,
	input  wire logic [NB_GPIOS-1:0]   i_gpio_in,
	output logic      [NB_GPIOS-1:0]   o_gpio_out,
	output logic                       o_invalid_opcode,
	output logic      [NB_OPCODE-1:0]  o_opcode
);

	logic                       enable_tx;
	logic                       enable_rx;
	logic [LEN_CODED_BLOCK-1:0] tx_block;
	logic                       tx_valid;
	logic [LEN_DATA_BLOCK-1:0]  rx_raw_data;
	logic [LEN_CTRL_BLOCK-1:0]  rx_raw_ctrl;
	logic                       rx_valid;	// Shared, logs fill in lockstep

	log_port_if #(.NB_WORD(LEN_DATA_BLOCK), .RAM_DEPTH(RAM_DEPTH)) data_log_port ();
	log_port_if #(.NB_WORD(LEN_CTRL_BLOCK), .RAM_DEPTH(RAM_DEPTH)) ctrl_log_port ();

	////////////////////
	// PCS loopback
	////////////////////
	pcs_tx_path
	u_pcs_tx_path
	(
		.i_clock	(i_clock),
		.i_rst_n	(i_rst_n),
		.i_enable	(enable_tx),
		.o_block	(tx_block),
		.o_valid	(tx_valid)
	);

	pcs_rx_path
	u_pcs_rx_path
	(
		.i_clock	(i_clock),
		.i_rst_n	(i_rst_n),
		.i_enable	(enable_rx),
		.i_block	(tx_block),
		.i_valid	(tx_valid),
		.o_rx_raw_data	(rx_raw_data),
		.o_rx_raw_ctrl	(rx_raw_ctrl),
		.o_valid	(rx_valid)
	);

	////////////////////
	// Logs and control
	////////////////////
	log_memory
	#(
		.NB_WORD	(LEN_DATA_BLOCK),
		.RAM_DEPTH	(RAM_DEPTH)
	)
	u_log_data_mem
	(
		.i_clock	(i_clock),
		.i_rst_n	(i_rst_n),
		.i_data		(rx_raw_data),
		.i_valid	(rx_valid),
		.port		(data_log_port)
	);

	log_memory
	#(
		.NB_WORD	(LEN_CTRL_BLOCK),
		.RAM_DEPTH	(RAM_DEPTH)
	)
	u_log_ctrl_mem
	(
		.i_clock	(i_clock),
		.i_rst_n	(i_rst_n),
		.i_data		(rx_raw_ctrl),
		.i_valid	(rx_valid),
		.port		(ctrl_log_port)
	);

	register_file
	#(
		.RAM_DEPTH	(RAM_DEPTH)
	)
	u_register_file
	(
		.i_clock		(i_clock),
		.i_rst_n		(i_rst_n),
		.i_gpio_in		(i_gpio_in),
		.o_gpio_out		(o_gpio_out),
		.data_port		(data_log_port),
		.ctrl_port		(ctrl_log_port),
		.o_enable_tx		(enable_tx),
		.o_enable_rx		(enable_rx),
		.o_invalid_opcode	(o_invalid_opcode),
		.o_opcode		(o_opcode)
	);

endmodule

`default_nettype wire

// File: verification_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module verification_asserts
	import regfile_pkg::*;
(
	input wire logic                  i_clock,
	input wire logic                  i_rst_n,
	input wire logic                  i_enable_tx,
	input wire logic                  i_enable_rx,
	input wire logic                  i_invalid_opcode,
	input wire logic [NB_OPCODE-1:0]  i_opcode,
	input wire logic                  i_log_run,
	input wire logic                  i_data_full,
	input wire logic                  i_ctrl_full
);

	////////////////////
	// Command checks
	////////////////////
	enables_low_after_reset: assert property (
		@(posedge i_clock) $rose(i_rst_n) |-> (!i_enable_tx && !i_enable_rx && !i_invalid_opcode)
	) else $error("Enable or invalid flag set when leaving reset");

	// Flag only rises together with an opcode outside the command set
	invalid_from_bad_opcode: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_invalid_opcode) |-> (i_opcode > OP_READ_STATUS)
	) else $error("Invalid opcode flag rose for a known opcode");

	////////////////////
	// Log checks
	////////////////////
	// Two cycles of run allow for the restart on the run edge
	data_full_holds: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		(i_log_run && $past(i_log_run) && $past(i_log_run, 2)) |-> !$fell(i_data_full)
	) else $error("Data log full dropped while running");

	ctrl_full_holds: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		(i_log_run && $past(i_log_run) && $past(i_log_run, 2)) |-> !$fell(i_ctrl_full)
	) else $error("Control log full dropped while running");

endmodule

bind register_file verification_asserts u_verification_asserts
(
	.i_clock		(i_clock),
	.i_rst_n		(i_rst_n),
	.i_enable_tx		(o_enable_tx),
	.i_enable_rx		(o_enable_rx),
	.i_invalid_opcode	(o_invalid_opcode),
	.i_opcode		(o_opcode),
	.i_log_run		(log_run),
	.i_data_full		(data_port.full),
	.i_ctrl_full		(ctrl_port.full)
);

`default_nettype wire

// File: tb_verification_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_verification_top
	import regfile_pkg::*;
	import pcs_pkg::*;
();

	localparam int DEPTH      = 16;
	localparam int POLL_LIMIT = 40;	// Status polls before giving up

	typedef enum {CHK_WORD, CHK_CTRL, CHK_OPCODE} check_kind_e;

	logic                 i_clock;
	logic                 i_rst_n;
	logic [NB_GPIOS-1:0]  i_gpio_in;
	logic [NB_GPIOS-1:0]  o_gpio_out;
	logic                 o_invalid_opcode;
	logic [NB_OPCODE-1:0] o_opcode;

	int          seed = 99;
	logic [31:0] k_base;	// Block index held in log entry 0
	check_kind_e chk_kind;
	logic [31:0] exp_word;
	opcode_e     exp_opcode;
	logic        exp_invalid;
	event        check_ev;

	verification_top_level
	#(
		.RAM_DEPTH	(DEPTH)
	)
	dut_i
	(
		.i_clock		(i_clock),
		.i_rst_n		(i_rst_n),
		.i_gpio_in		(i_gpio_in),
		.o_gpio_out		(o_gpio_out),
		.o_invalid_opcode	(o_invalid_opcode),
		.o_opcode		(o_opcode)
	);

	always #20 i_clock = ~i_clock;

	////////////////////
	// Reference model
	////////////////////
	// Returns {ctrl, data} for generator block k
	function automatic logic [71:0] block_ref(input logic [31:0] k);
		if (k % IDLE_PERIOD == IDLE_PERIOD - 1) begin
			return {8'hFF, {8{8'h07}}};	// All-idle block
		end
		return {8'h00, k, ~k};
	endfunction

	////////////////////
	// Compare tasks
	////////////////////
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic compare_ctrl(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s got 0x%02h expected 0x%02h", name, got, exp));
		end
	endtask

	task automatic compare_opcode(input string name, input opcode_e got, input opcode_e exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s got 0x%03h expected 0x%03h", name, got, exp));
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s got 0x%01h expected 0x%01h", name, got, exp));
		end
	endtask

	// Checker process, runs on each request while outputs are stable
	always @(check_ev) begin
		case (chk_kind)
			CHK_WORD: compare_word("o_gpio_out", o_gpio_out, exp_word);
			CHK_CTRL: begin
				compare_ctrl("o_gpio_out[7:0]", o_gpio_out[7:0], exp_word[7:0]);
				compare_word("o_gpio_out", o_gpio_out, exp_word);	// Zero-extended
			end
			CHK_OPCODE: begin
				compare_opcode("o_opcode", opcode_e'(o_opcode), exp_opcode);
				compare_flag("o_invalid_opcode", o_invalid_opcode, exp_invalid);
			end
			default: ;
		endcase
	end

	task automatic expect_word(input logic [31:0] exp);
		chk_kind = CHK_WORD;
		exp_word = exp;
		-> check_ev;
		@(negedge i_clock);
	endtask

	task automatic expect_ctrl(input logic [7:0] exp);
		chk_kind = CHK_CTRL;
		exp_word = {24'h0, exp};
		-> check_ev;
		@(negedge i_clock);
	endtask

	task automatic expect_opcode(input logic [NB_OPCODE-1:0] op, input logic invalid);
		chk_kind    = CHK_OPCODE;
		exp_opcode  = opcode_e'(op);
		exp_invalid = invalid;
		-> check_ev;
		@(negedge i_clock);
	endtask

	////////////////////
	// GPIO commands
	////////////////////
	// Raise the strobe, hold it until the result has settled, then drop it
	task automatic send_command(input logic [NB_OPCODE-1:0] op, input logic [NB_ARG-1:0] arg);
		@(negedge i_clock);
		i_gpio_in = {1'b1, op, arg};
		repeat (4) @(negedge i_clock);
		i_gpio_in[STROBE_BIT] = 1'b0;
	endtask

	task automatic wait_logs_full();
		int polls;
		polls = 0;
		send_command(OP_READ_STATUS, '0);
		while (o_gpio_out[31:30] != 2'b11) begin
			if (polls == POLL_LIMIT) begin
				fail_run("Timeout waiting for both logs to report full");
			end else begin
				polls++;
				send_command(OP_READ_STATUS, '0);
			end
		end
		expect_word({2'b11, 30'(DEPTH)});	// Count equals depth
	endtask

	// Find k of entry 0, then walk every address
	task automatic check_log_contents();
		logic [71:0] ref_blk;
		send_command(OP_SET_ADDR, '0);
		send_command(OP_READ_CTRL, '0);
		if (o_gpio_out[7:0] == 8'hFF) begin
			send_command(OP_SET_ADDR, 22'd1);	// Idle entry holds no index
			send_command(OP_READ_DATA_HI, '0);
			k_base = o_gpio_out - 32'd1;
		end else begin
			send_command(OP_READ_DATA_HI, '0);
			k_base = o_gpio_out;
		end
		for (int a = 0; a < DEPTH; a++) begin
			ref_blk = block_ref(k_base + a);
			send_command(OP_SET_ADDR, 22'(a));
			send_command(OP_READ_DATA_LO, '0);
			expect_word(ref_blk[31:0]);
			send_command(OP_READ_DATA_HI, '0);
			expect_word(ref_blk[63:32]);
			send_command(OP_READ_CTRL, '0);
			expect_ctrl(ref_blk[71:64]);
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////
	initial begin
		logic [NB_OPCODE-1:0] bad_op;
		int                   addr;
		logic [71:0]          ref_blk;
		i_clock   = 1'b0;
		i_rst_n   = 1'b0;
		i_gpio_in = '0;
		repeat (10) @(negedge i_clock);
		i_rst_n = 1'b1;

		expect_word(32'h0);	// Reset state
		expect_opcode(OP_NOP, 1'b0);
		send_command(OP_READ_STATUS, '0);
		expect_word(32'h0);
		expect_opcode(OP_READ_STATUS, 1'b0);

		send_command(OP_TX_ENABLE, 22'd1);
		send_command(OP_RX_ENABLE, 22'd1);
		send_command(OP_LOG_RUN, 22'd1);
		wait_logs_full();
		check_log_contents();

		// Stop and restart the logs
		send_command(OP_LOG_RUN, 22'd0);
		send_command(OP_LOG_RUN, 22'd1);
		send_command(OP_READ_STATUS, '0);
		if (o_gpio_out[31:30] != 2'b00 || o_gpio_out[29:0] >= 30'(DEPTH)) begin
			fail_run("Log count did not restart after the logs were run again");
		end
		wait_logs_full();
		check_log_contents();

		// Unknown opcode, then a valid one clears the flag
		bad_op = 9'd9 + 9'($unsigned($random(seed)) % 503);
		send_command(bad_op, 22'($random(seed)));
		expect_opcode(bad_op, 1'b1);
		send_command(OP_READ_STATUS, '0);
		expect_opcode(OP_READ_STATUS, 1'b0);
		expect_word({2'b11, 30'(DEPTH)});

		for (int n = 0; n < 24; n++) begin
			addr    = int'($unsigned($random(seed)) % DEPTH);
			ref_blk = block_ref(k_base + addr);
			send_command(OP_SET_ADDR, 22'(addr));
			case ($unsigned($random(seed)) % 4)
				0: begin
					send_command(OP_READ_DATA_LO, 22'($random(seed)));
					expect_word(ref_blk[31:0]);
				end
				1: begin
					send_command(OP_READ_DATA_HI, 22'($random(seed)));
					expect_word(ref_blk[63:32]);
				end
				2: begin
					send_command(OP_READ_CTRL, 22'($random(seed)));
					expect_ctrl(ref_blk[71:64]);
				end
				default: begin
					send_command(OP_READ_STATUS, 22'($random(seed)));
					expect_word({2'b11, 30'(DEPTH)});
				end
			endcase
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
pcs_pkg.sv
regfile_pkg.sv
log_port_if.sv
pcs_tx_path.sv
pcs_rx_path.sv
log_memory.sv
register_file.sv
verification_top_level.sv
verification_asserts.sv
tb_verification_top.sv

// File: Makefile
TOP = tb_verification_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation passed" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log
